// File: hdl/attn_settings.svh
// fixed 8-wide model; T is limited to 1, 4 or 8 and all widths assume 6-bit X and 8-bit weights
`ifndef ATTN_SETTINGS_SVH
`define ATTN_SETTINGS_SVH

// model dimension, both the row length and the weight matrix size
`define ATTN_DIM        8

// element widths
`define ATTN_X_W        6
`define ATTN_W_W        8
`define ATTN_QKV_W      19
`define ATTN_SCORE_W    37
`define ATTN_OUT_W      59

// Wq, Wk and Wv arrive back to back in one burst
`define ATTN_LOAD_BEATS 192

// clamped scores are divided by this, rounding down
`define ATTN_SCORE_DIV  3

`endif

// File: hdl/attn_pkg.sv
// shared types; the phase order of phase_t is relied on by the sequencer
`include "attn_settings.svh"

package attn_pkg;

    typedef logic signed [`ATTN_X_W-1:0]     x_t;
    typedef logic signed [`ATTN_W_W-1:0]     weight_t;
    typedef logic signed [`ATTN_QKV_W-1:0]   qkv_t;
    // never negative after the clamp, kept signed for the S*V products
    typedef logic signed [`ATTN_SCORE_W-1:0] score_t;
    typedef logic signed [`ATTN_OUT_W-1:0]   out_t;
    typedef logic [3:0]                      tlen_t;
    typedef logic [$clog2(`ATTN_DIM)-1:0]    idx_t;

    // compute phases follow PH_LOAD in issue order
    typedef enum logic [2:0] {
        PH_IDLE,
        PH_LOAD,
        PH_PROJ_Q,
        PH_PROJ_K,
        PH_PROJ_V,
        PH_SCORE,
        PH_WEIGH
    } phase_t;

endpackage

// File: hdl/attn_if.sv
// internal bundles only; no handshake, storage reads are combinational
`include "attn_settings.svh"

// one sequencer step per cycle, never stalled
interface step_if;
    logic             issue;
    attn_pkg::phase_t phase;
    attn_pkg::idx_t   row;
    attn_pkg::idx_t   col;
    logic             last;

    modport drv (output issue, phase, row, col, last);
    modport rcv (input issue, phase, row, col, last);
endinterface

// Q and K rows plus one V column, served from projection storage
interface qkv_rd_if;
    attn_pkg::idx_t q_row_sel;
    attn_pkg::idx_t k_row_sel;
    attn_pkg::idx_t v_col_sel;
    attn_pkg::qkv_t q_vec [`ATTN_DIM];
    attn_pkg::qkv_t k_vec [`ATTN_DIM];
    attn_pkg::qkv_t v_vec [`ATTN_DIM];

    modport src (input q_row_sel, k_row_sel, v_col_sel, output q_vec, k_vec, v_vec);
    // score drives the row selects, weighted sum drives the column select
    modport sink (output q_row_sel, k_row_sel, v_col_sel, input q_vec, k_vec, v_vec);
endinterface

// File: hdl/attn_input_buffer.sv
// expects in_valid high for exactly 192 beats; X rows at or above T keep stale data
`include "attn_settings.svh"

module attn_input_buffer (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              in_valid,
    input  attn_pkg::tlen_t   t_len,
    input  attn_pkg::x_t      x_in,
    input  attn_pkg::weight_t wq_in,
    input  attn_pkg::weight_t wk_in,
    input  attn_pkg::weight_t wv_in,
    input  attn_pkg::idx_t    x_row_sel,
    input  attn_pkg::idx_t    w_col_sel,
    input  attn_pkg::phase_t  w_mat_sel,
    output attn_pkg::tlen_t   t_reg,
    output logic              load_done,
    output attn_pkg::x_t      x_vec [`ATTN_DIM],
    output attn_pkg::weight_t w_vec [`ATTN_DIM]
);

    localparam logic [7:0] LAST_BEAT = 8'(`ATTN_LOAD_BEATS - 1);

    logic [7:0]        beat;
    attn_pkg::tlen_t   t_cur;
    logic              x_wr;
    attn_pkg::weight_t w_in;
    logic [1:0]        mat_rd;
    attn_pkg::x_t      x_mem [`ATTN_DIM][`ATTN_DIM];
    // index 0 is Wq, 1 is Wk, 2 is Wv
    attn_pkg::weight_t w_mem [3][`ATTN_DIM][`ATTN_DIM];

    // on beat 0 T comes straight from the port, it is latched at the same edge
    assign t_cur = (beat == 8'd0) ? t_len : t_reg;
    assign x_wr  = in_valid && (beat < {1'b0, t_cur, 3'b000});

    // the three matrices come in consecutive 64-beat blocks
    always_comb begin
        case (beat[7:6])
            2'd0:    w_in = wq_in;
            2'd1:    w_in = wk_in;
            default: w_in = wv_in;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            beat      <= '0;
            t_reg     <= '0;
            load_done <= 1'b0;
        end else begin
            load_done <= in_valid && (beat == LAST_BEAT);
            if (in_valid) begin
                beat <= (beat == LAST_BEAT) ? 8'd0 : beat + 8'd1;
            end
            if (in_valid && beat == 8'd0) begin
                t_reg <= t_len;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (x_wr) begin
            x_mem[beat[5:3]][beat[2:0]] <= x_in;
        end
        if (in_valid) begin
            w_mem[beat[7:6]][beat[5:3]][beat[2:0]] <= w_in;
        end
    end

    // one X row and one weight column, matrix picked by the projection phase
    always_comb begin
        case (w_mat_sel)
            attn_pkg::PH_PROJ_K: mat_rd = 2'd1;
            attn_pkg::PH_PROJ_V: mat_rd = 2'd2;
            default:             mat_rd = 2'd0;
        endcase
        for (int i = 0; i < `ATTN_DIM; i++) begin
            x_vec[i] = x_mem[x_row_sel][i];
            w_vec[i] = w_mem[mat_rd][i][w_col_sel];
        end
    end

    a_t_legal: assert property (@(posedge clk) disable iff (!rst_n)
        (in_valid && beat == 8'd0) |-> (t_len inside {4'd1, 4'd4, 4'd8}));

endmodule

// File: hdl/attn_sequencer.sv
// issues one step per cycle without stall; t_reg must hold 1, 4 or 8 once PH_PROJ_Q starts
`include "attn_settings.svh"

module attn_sequencer (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            in_valid,
    input  logic            load_done,
    input  attn_pkg::tlen_t t_reg,
    step_if.drv             step
);

    // idle cycles so that V and S storage is complete before it is read
    localparam logic [1:0] DRAIN_GAP = 2'd3;

    attn_pkg::phase_t phase;
    attn_pkg::phase_t phase_next;
    attn_pkg::idx_t   row;
    attn_pkg::idx_t   col;
    attn_pkg::idx_t   row_max;
    attn_pkg::idx_t   col_max;
    logic [1:0]       gap;
    logic             row_end;
    logic             col_end;

    assign row_max = attn_pkg::idx_t'(t_reg - 4'd1);
    // score columns run over tokens, every other phase over the model dimension
    assign col_max = (phase == attn_pkg::PH_SCORE) ? row_max
                                                   : attn_pkg::idx_t'(`ATTN_DIM - 1);
    assign row_end = (row == row_max);
    assign col_end = (col == col_max);

    assign step.phase = phase;
    assign step.row   = row;
    assign step.col   = col;
    assign step.issue = (phase >= attn_pkg::PH_PROJ_Q) && (gap == 2'd0);
    assign step.last  = step.issue && row_end && col_end;

    always_comb begin
        case (phase)
            attn_pkg::PH_PROJ_Q: phase_next = attn_pkg::PH_PROJ_K;
            attn_pkg::PH_PROJ_K: phase_next = attn_pkg::PH_PROJ_V;
            attn_pkg::PH_PROJ_V: phase_next = attn_pkg::PH_SCORE;
            attn_pkg::PH_SCORE:  phase_next = attn_pkg::PH_WEIGH;
            default:             phase_next = attn_pkg::PH_IDLE;
        endcase
    end

    // ########################################################################
    // phase FSM with row and column counters
    // ########################################################################
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase <= attn_pkg::PH_IDLE;
            row   <= '0;
            col   <= '0;
            gap   <= '0;
        end else if (gap != 2'd0) begin
            gap <= gap - 2'd1;
        end else begin
            case (phase)
                attn_pkg::PH_IDLE: begin
                    if (in_valid) begin
                        phase <= attn_pkg::PH_LOAD;
                    end
                end
                attn_pkg::PH_LOAD: begin
                    if (load_done) begin
                        phase <= attn_pkg::PH_PROJ_Q;
                    end
                end
                default: begin
                    col <= col_end ? '0 : col + 1'b1;
                    if (col_end) begin
                        row <= row_end ? '0 : row + 1'b1;
                    end
                    if (step.last) begin
                        phase <= phase_next;
                        // drain after V and after S
                        if (phase == attn_pkg::PH_PROJ_V || phase == attn_pkg::PH_SCORE) begin
                            gap <= DRAIN_GAP;
                        end
                    end
                end
            endcase
        end
    end

    // a new burst must not start while steps of the previous one are still issued
    a_no_issue_during_load: assert property (@(posedge clk) disable iff (!rst_n)
        in_valid |-> !step.issue);

endmodule

// File: hdl/attn_projection.sv
// Q, K and V land two cycles after issue; rows at or above T hold old results
`include "attn_settings.svh"

module attn_projection (
    input  logic              clk,
    input  logic              rst_n,
    step_if.rcv               step,
    input  attn_pkg::x_t      x_vec [`ATTN_DIM],
    input  attn_pkg::weight_t w_vec [`ATTN_DIM],
    output attn_pkg::idx_t    x_row_sel,
    output attn_pkg::idx_t    w_col_sel,
    output attn_pkg::phase_t  w_mat_sel,
    qkv_rd_if.src             rd
);

    logic              proj_step;
    logic [1:0]        step_mat;
    attn_pkg::x_t      op_x [`ATTN_DIM];
    attn_pkg::weight_t op_w [`ATTN_DIM];
    logic              op_vld;
    logic [1:0]        op_mat;
    attn_pkg::idx_t    op_row;
    attn_pkg::idx_t    op_col;
    attn_pkg::qkv_t    tree;
    attn_pkg::qkv_t    sum_q;
    logic              sum_vld;
    logic [1:0]        sum_mat;
    attn_pkg::idx_t    sum_row;
    attn_pkg::idx_t    sum_col;
    // index 0 is Q, 1 is K, 2 is V
    attn_pkg::qkv_t    mem [3][`ATTN_DIM][`ATTN_DIM];

    assign x_row_sel = step.row;
    assign w_col_sel = step.col;
    assign w_mat_sel = step.phase;

    always_comb begin
        proj_step = step.issue;
        case (step.phase)
            attn_pkg::PH_PROJ_Q: step_mat = 2'd0;
            attn_pkg::PH_PROJ_K: step_mat = 2'd1;
            attn_pkg::PH_PROJ_V: step_mat = 2'd2;
            default: begin
                step_mat  = 2'd0;
                proj_step = 1'b0;
            end
        endcase
    end

    // ########################################################################
    // operand stage, then sum stage
    // ########################################################################
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            op_vld  <= 1'b0;
            sum_vld <= 1'b0;
        end else begin
            op_vld  <= proj_step;
            sum_vld <= op_vld;
        end
    end

    always_ff @(posedge clk) begin
        op_x    <= x_vec;
        op_w    <= w_vec;
        op_mat  <= step_mat;
        op_row  <= step.row;
        op_col  <= step.col;
        sum_q   <= tree;
        sum_mat <= op_mat;
        sum_row <= op_row;
        sum_col <= op_col;
    end

    // eight 6x8 products; the total fits 17 bits, so 19 never overflows
    always_comb begin
        tree = '0;
        for (int i = 0; i < `ATTN_DIM; i++) begin
            tree = tree + op_x[i] * op_w[i];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            foreach (mem[m, r, c]) begin
                mem[m][r][c] <= '0;
            end
        end else if (sum_vld) begin
            mem[sum_mat][sum_row][sum_col] <= sum_q;
        end
    end

    // V is read by column for the weighted sum
    always_comb begin
        for (int i = 0; i < `ATTN_DIM; i++) begin
            rd.q_vec[i] = mem[0][rd.q_row_sel][i];
            rd.k_vec[i] = mem[1][rd.k_row_sel][i];
            rd.v_vec[i] = mem[2][i][rd.v_col_sel];
        end
    end

endmodule

// File: hdl/attn_score.sv
// S lands three cycles after issue; each row is cleared as its column 0 lands
`include "attn_settings.svh"

module attn_score (
    input  logic             clk,
    input  logic             rst_n,
    step_if.rcv              step,
    qkv_rd_if.sink           rd,
    input  attn_pkg::idx_t   s_row_sel,
    output attn_pkg::score_t s_vec [`ATTN_DIM]
);

    logic                          score_step;
    logic signed [`ATTN_SCORE_W:0] dot;
    logic signed [`ATTN_SCORE_W:0] dot_q;
    logic [`ATTN_SCORE_W-1:0]      clamp_q;
    attn_pkg::score_t              div_q;
    logic [2:0]                    vld;
    attn_pkg::idx_t                row_d [3];
    attn_pkg::idx_t                col_d [3];
    attn_pkg::score_t              s_mem [`ATTN_DIM][`ATTN_DIM];

    assign score_step   = step.issue && (step.phase == attn_pkg::PH_SCORE);
    assign rd.q_row_sel = step.row;
    assign rd.k_row_sel = step.col;

    // Q row dot K row in 38 bits
    always_comb begin
        dot = '0;
        for (int i = 0; i < `ATTN_DIM; i++) begin
            dot = dot + rd.q_vec[i] * rd.k_vec[i];
        end
    end

    // ########################################################################
    // product, clamp and divide stages
    // ########################################################################
    always_ff @(posedge clk) begin
        dot_q    <= dot;
        clamp_q  <= dot_q[`ATTN_SCORE_W] ? '0 : dot_q[`ATTN_SCORE_W-1:0];
        div_q    <= attn_pkg::score_t'(clamp_q / `ATTN_SCORE_DIV);
        row_d[0] <= step.row;
        row_d[1] <= row_d[0];
        row_d[2] <= row_d[1];
        col_d[0] <= step.col;
        col_d[1] <= col_d[0];
        col_d[2] <= col_d[1];
    end

    // columns at or above T must read as zero, stale V rows sit behind them
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            vld <= '0;
            foreach (s_mem[r, c]) begin
                s_mem[r][c] <= '0;
            end
        end else begin
            vld <= {vld[1:0], score_step};
            if (vld[2]) begin
                for (int j = 0; j < `ATTN_DIM; j++) begin
                    if (j == col_d[2]) begin
                        s_mem[row_d[2]][j] <= div_q;
                    end else if (col_d[2] == '0) begin
                        s_mem[row_d[2]][j] <= '0;
                    end
                end
            end
        end
    end

    always_comb begin
        for (int i = 0; i < `ATTN_DIM; i++) begin
            s_vec[i] = s_mem[s_row_sel][i];
        end
    end

    // the drain gap must let every S write land before the weighted sum reads
    a_s_complete_before_read: assert property (@(posedge clk) disable iff (!rst_n)
        (step.issue && step.phase == attn_pkg::PH_WEIGH) |-> (vld == '0));

endmodule

// File: hdl/attn_weighted_sum.sv
// out_valid follows each PH_WEIGH step by two cycles; no back-pressure on the output
`include "attn_settings.svh"

module attn_weighted_sum (
    input  logic             clk,
    input  logic             rst_n,
    step_if.rcv              step,
    qkv_rd_if.sink           rd,
    input  attn_pkg::score_t s_vec [`ATTN_DIM],
    output attn_pkg::idx_t   s_row_sel,
    output logic             out_valid,
    output attn_pkg::out_t   out_data
);

    logic           wsum_step;
    logic           sum_vld;
    attn_pkg::out_t acc;
    attn_pkg::out_t sum_q;

    assign wsum_step    = step.issue && (step.phase == attn_pkg::PH_WEIGH);
    assign s_row_sel    = step.row;
    assign rd.v_col_sel = step.col;

    // S row r dot V column c
    always_comb begin
        acc = '0;
        for (int i = 0; i < `ATTN_DIM; i++) begin
            acc = acc + s_vec[i] * rd.v_vec[i];
        end
    end

    always_ff @(posedge clk) begin
        sum_q <= acc;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sum_vld   <= 1'b0;
            out_valid <= 1'b0;
            out_data  <= '0;
        end else begin
            sum_vld   <= wsum_step;
            out_valid <= sum_vld;
            out_data  <= sum_vld ? sum_q : '0;
        end
    end

    // PH_WEIGH steps come back to back, so the output burst has no holes
    a_weigh_steps_contiguous: assert property (@(posedge clk) disable iff (!rst_n)
        (wsum_step && !step.last) |=> wsum_step);

endmodule

// File: hdl/attn_top.sv
// in_valid must stay high 192 cycles, and a new burst waits until the last output
`include "attn_settings.svh"

module attn_top (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              in_valid,
    input  attn_pkg::tlen_t   t_len,
    input  attn_pkg::x_t      x_in,
    input  attn_pkg::weight_t wq_in,
    input  attn_pkg::weight_t wk_in,
    input  attn_pkg::weight_t wv_in,
    output logic              out_valid,
    output attn_pkg::out_t    out_data
);

    attn_pkg::tlen_t   t_reg;
    logic              load_done;
    attn_pkg::idx_t    x_row_sel;
    attn_pkg::idx_t    w_col_sel;
    attn_pkg::idx_t    s_row_sel;
    attn_pkg::phase_t  w_mat_sel;
    attn_pkg::x_t      x_vec [`ATTN_DIM];
    attn_pkg::weight_t w_vec [`ATTN_DIM];
    attn_pkg::score_t  s_vec [`ATTN_DIM];

    step_if   u_step ();
    qkv_rd_if u_rd ();

    attn_input_buffer u_input_buffer (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .t_len     (t_len),
        .x_in      (x_in),
        .wq_in     (wq_in),
        .wk_in     (wk_in),
        .wv_in     (wv_in),
        .x_row_sel (x_row_sel),
        .w_col_sel (w_col_sel),
        .w_mat_sel (w_mat_sel),
        .t_reg     (t_reg),
        .load_done (load_done),
        .x_vec     (x_vec),
        .w_vec     (w_vec)
    );

    attn_sequencer u_sequencer (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .load_done (load_done),
        .t_reg     (t_reg),
        .step      (u_step.drv)
    );

    attn_projection u_projection (
        .clk       (clk),
        .rst_n     (rst_n),
        .step      (u_step.rcv),
        .x_vec     (x_vec),
        .w_vec     (w_vec),
        .x_row_sel (x_row_sel),
        .w_col_sel (w_col_sel),
        .w_mat_sel (w_mat_sel),
        .rd        (u_rd.src)
    );

    attn_score u_score (
        .clk       (clk),
        .rst_n     (rst_n),
        .step      (u_step.rcv),
        .rd        (u_rd.sink),
        .s_row_sel (s_row_sel),
        .s_vec     (s_vec)
    );

    attn_weighted_sum u_weighted_sum (
        .clk       (clk),
        .rst_n     (rst_n),
        .step      (u_step.rcv),
        .rd        (u_rd.sink),
        .s_vec     (s_vec),
        .s_row_sel (s_row_sel),
        .out_valid (out_valid),
        .out_data  (out_data)
    );

endmodule

// File: test/tb_attn.sv
// bursts are sent only after the previous output ends; outputs are sampled on the falling edge
`include "attn_settings.svh"

module tb_attn;

    localparam int CLK_PERIOD   = 4;
    localparam int RESET_CYCLES = 8;
    localparam int IDLE_CYCLES  = 4;
    localparam int SEED         = 34927;
    localparam int D            = `ATTN_DIM;
    localparam int NUM_CASES    = 7;
    localparam int KIND_RAND    = 0;
    localparam int KIND_NEG     = 1;
    localparam int KIND_MAX     = 2;
    localparam int KIND_HAND    = 3;

    logic                           clk;
    logic                           rst_n;
    logic                           in_valid;
    logic [3:0]                     t_len;
    logic signed [`ATTN_X_W-1:0]    x_in;
    logic signed [`ATTN_W_W-1:0]    wq_in;
    logic signed [`ATTN_W_W-1:0]    wk_in;
    logic signed [`ATTN_W_W-1:0]    wv_in;
    logic                           out_valid;
    logic signed [`ATTN_OUT_W-1:0]  out_data;

    int     errors;
    int     checks;
    int     x_m  [D][D];
    int     wq_m [D][D];
    int     wk_m [D][D];
    int     wv_m [D][D];
    longint ref_o [D * D];

    // case table: name, T, pattern, and O[0][0] worked out by hand (-1 if none)
    string  case_name  [NUM_CASES] = '{"rand_t1", "rand_t4", "rand_t8", "neg_score_t4",
                                       "floor_div_t1", "max_mag_t8", "rand_t4_after_t8"};
    int     case_t     [NUM_CASES] = '{1, 4, 8, 4, 1, 8, 4};
    int     case_kind  [NUM_CASES] = '{KIND_RAND, KIND_RAND, KIND_RAND, KIND_NEG,
                                       KIND_HAND, KIND_MAX, KIND_RAND};
    // max case: S = floor(2^33 / 3), V = 2^15, eight terms
    longint case_first [NUM_CASES] = '{-1, -1, -1, -1, 3, 64'sd750599937720320, -1};

    attn_top u_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .t_len     (t_len),
        .x_in      (x_in),
        .wq_in     (wq_in),
        .wk_in     (wk_in),
        .wv_in     (wv_in),
        .out_valid (out_valid),
        .out_data  (out_data)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic int rand_x();
        return int'($urandom_range(63)) - 32;
    endfunction

    function automatic int rand_w();
        return int'($urandom_range(255)) - 128;
    endfunction

    function automatic int case_cycles(input int t);
        return `ATTN_LOAD_BEATS + 3 * t * D + t * t + t * D + 20;
    endfunction

    // ########################################################################
    // checks
    // ########################################################################
    task automatic check_idle(input string name);
        checks++;
        assert (!out_valid) else begin
            errors++;
            $display("%s: out_valid is high outside an output window", name);
        end
        assert (out_data == '0) else begin
            errors++;
            $display("Error %s idle out_data: expected 0, actual %0d", name, out_data);
        end
    endtask

    task automatic compare_output(input string name, input int idx, input longint exp_val,
                                  input longint act_val);
        checks++;
        assert (act_val == exp_val) else begin
            errors++;
            $display("Error %s O[%0d][%0d]: expected %0d, actual %0d",
                     name, idx / D, idx % D, exp_val, act_val);
        end
    endtask

    // ########################################################################
    // stimulus and reference model
    // ########################################################################
    task automatic generate_data(input int kind);
        for (int r = 0; r < D; r++) begin
            for (int c = 0; c < D; c++) begin
                case (kind)
                    KIND_NEG: begin
                        // positive Q against negative K makes every dot product negative
                        x_m[r][c]  = int'($urandom_range(31, 1));
                        wq_m[r][c] = int'($urandom_range(127, 1));
                        wk_m[r][c] = -int'($urandom_range(128, 1));
                        wv_m[r][c] = rand_w();
                    end
                    KIND_MAX: begin
                        x_m[r][c]  = -32;
                        wq_m[r][c] = -128;
                        wk_m[r][c] = -128;
                        wv_m[r][c] = -128;
                    end
                    default: begin
                        x_m[r][c]  = rand_x();
                        wq_m[r][c] = rand_w();
                        wk_m[r][c] = rand_w();
                        wv_m[r][c] = rand_w();
                    end
                endcase
            end
        end
        if (kind == KIND_HAND) begin
            // Q row 0 is (1,0..) and K row 0 is (11,0..), so the score 11 / 3 rounds down to 3
            for (int c = 0; c < D; c++) begin
                x_m[0][c]  = (c == 0) ? 1 : 0;
                wq_m[0][c] = (c == 0) ? 1 : 0;
                wk_m[0][c] = (c == 0) ? 11 : 0;
                wv_m[0][c] = c + 1;
            end
        end
    endtask

    task automatic compute_reference(input int t);
        longint q [D][D];
        longint k [D][D];
        longint v [D][D];
        longint s [D][D];
        longint acc;
        for (int r = 0; r < t; r++) begin
            for (int c = 0; c < D; c++) begin
                q[r][c] = 0;
                k[r][c] = 0;
                v[r][c] = 0;
                for (int i = 0; i < D; i++) begin
                    q[r][c] += longint'(x_m[r][i]) * longint'(wq_m[i][c]);
                    k[r][c] += longint'(x_m[r][i]) * longint'(wk_m[i][c]);
                    v[r][c] += longint'(x_m[r][i]) * longint'(wv_m[i][c]);
                end
            end
        end
        // negative scores clamp to zero, the rest divide rounding down
        for (int r = 0; r < t; r++) begin
            for (int c = 0; c < t; c++) begin
                acc = 0;
                for (int i = 0; i < D; i++) begin
                    acc += q[r][i] * k[c][i];
                end
                s[r][c] = (acc < 0) ? 0 : acc / `ATTN_SCORE_DIV;
            end
        end
        for (int r = 0; r < t; r++) begin
            for (int c = 0; c < D; c++) begin
                acc = 0;
                for (int j = 0; j < t; j++) begin
                    acc += s[r][j] * v[j][c];
                end
                ref_o[r * D + c] = acc;
            end
        end
    endtask

    // unused beats carry random values, which the DUT must ignore
    task automatic send_burst(input string name, input int t);
        int r;
        int c;
        int xv;
        int qv;
        int kv;
        int vv;
        for (int beat = 0; beat < `ATTN_LOAD_BEATS; beat++) begin
            @(negedge clk);
            check_idle(name);
            r = (beat % 64) / D;
            c = beat % D;
            if (beat < t * D) begin
                xv = x_m[beat / D][c];
            end else begin
                xv = rand_x();
            end
            qv = (beat < 64) ? wq_m[r][c] : rand_w();
            kv = (beat >= 64 && beat < 128) ? wk_m[r][c] : rand_w();
            vv = (beat >= 128) ? wv_m[r][c] : rand_w();
            in_valid = 1'b1;
            t_len    = t[3:0];
            x_in     = xv[`ATTN_X_W-1:0];
            wq_in    = qv[`ATTN_W_W-1:0];
            wk_in    = kv[`ATTN_W_W-1:0];
            wv_in    = vv[`ATTN_W_W-1:0];
        end
        @(negedge clk);
        check_idle(name);
        in_valid = 1'b0;
        t_len    = '0;
        x_in     = '0;
        wq_in    = '0;
        wk_in    = '0;
        wv_in    = '0;
    endtask

    task automatic collect_output(input int ci);
        int     t;
        int     wait_limit;
        int     waited;
        longint act;
        string  name;
        t          = case_t[ci];
        name       = case_name[ci];
        wait_limit = 3 * t * D + t * t + 20;
        waited     = 0;
        @(negedge clk);
        while (!out_valid && waited < wait_limit) begin
            check_idle(name);
            waited++;
            @(negedge clk);
        end
        checks++;
        assert (out_valid) else begin
            errors++;
            $display("%s: no output within %0d cycles after the burst", name, wait_limit);
        end
        if (out_valid) begin
            for (int idx = 0; idx < t * D; idx++) begin
                if (idx > 0) begin
                    @(negedge clk);
                end
                checks++;
                assert (out_valid) else begin
                    errors++;
                    $display("%s: out_valid dropped after %0d of %0d outputs", name, idx, t * D);
                end
                act = longint'(out_data);
                compare_output(name, idx, ref_o[idx], act);
                if (case_kind[ci] == KIND_NEG) begin
                    compare_output(name, idx, 0, act);
                end
                if (idx == 0 && case_first[ci] >= 0) begin
                    compare_output(name, idx, case_first[ci], act);
                end
            end
            @(negedge clk);
            checks++;
            assert (!out_valid) else begin
                errors++;
                $display("%s: out_valid stays high after %0d outputs", name, t * D);
            end
        end
    endtask

    // ########################################################################
    // main sequence and watchdog
    // ########################################################################
    initial begin
        void'($urandom(SEED));
        clk      = 1'b0;
        rst_n    = 1'b0;
        in_valid = 1'b0;
        t_len    = '0;
        x_in     = '0;
        wq_in    = '0;
        wk_in    = '0;
        wv_in    = '0;
        errors   = 0;
        checks   = 0;
        repeat (RESET_CYCLES) begin
            @(negedge clk);
            check_idle("reset");
        end
        rst_n = 1'b1;
        repeat (IDLE_CYCLES) begin
            @(negedge clk);
            check_idle("after_reset");
        end
        for (int ci = 0; ci < NUM_CASES; ci++) begin
            generate_data(case_kind[ci]);
            compute_reference(case_t[ci]);
            send_burst(case_name[ci], case_t[ci]);
            collect_output(ci);
        end
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    initial begin
        int limit;
        limit = RESET_CYCLES + IDLE_CYCLES;
        for (int ci = 0; ci < NUM_CASES; ci++) begin
            limit += case_cycles(case_t[ci]);
        end
        #(limit * CLK_PERIOD);
        $display("timeout: the run did not finish within %0d cycles, checks: %0d, errors: %0d",
                 limit, checks, errors);
        $display("Test FAILED");
        $finish;
    end

endmodule

// File: project.f
+incdir+hdl
hdl/attn_pkg.sv
hdl/attn_if.sv
hdl/attn_input_buffer.sv
hdl/attn_sequencer.sv
hdl/attn_projection.sv
hdl/attn_score.sv
hdl/attn_weighted_sum.sv
hdl/attn_top.sv
test/tb_attn.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_attn
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build $(TOP) with Verilator, run it and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "Test OK" $(LOG) || { echo "simulation did not pass, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
